// File: testbench/program_input.txt
# program: word count (decimal), then "address word" per line in hex; text after is a note
# expect: record count (decimal), then "retire_pc wb_en wb_addr wb_data name", fields in hex
22
00 7100000c  ldi  r1, 12
01 7200fff6  ldi  r2, -10
02 03120000  add  r3, r1, r2
03 14120000  sub  r4, r1, r2
04 25120000  and  r5, r1, r2
05 36120000  or   r6, r1, r2
06 47120000  xor  r7, r1, r2
07 58120000  slt  r8, r1, r2
08 59210000  slt  r9, r2, r1
09 6a10ffec  addi r10, r1, -20
0a 90170030  st   r7, 0x30(r1)
0b 8b100030  ld   r11, 0x30(r1)
0c a0120005  beq  r1, r2, +5
0d a0330002  beq  r3, r3, +2
0e 7c000bad  ldi  r12, never reached
0f b0110003  bne  r1, r1, +3
10 b0120002  bne  r1, r2, +2
11 7c000bad  ldi  r12, never reached
12 cd000004  jal  r13, +4
16 70000077  ldi  r0, 0x77
17 0e010000  add  r14, r0, r1
18 f0000000  halt
20
00 1 1 0000000c ldi_pos
01 1 2 fffffff6 ldi_neg
02 1 3 00000002 add
03 1 4 00000016 sub
04 1 5 00000004 and
05 1 6 fffffffe or
06 1 7 fffffffa xor
07 1 8 00000000 slt_false
08 1 9 00000001 slt_true
09 1 a fffffff8 addi
0a 0 0 00000000 store
0b 1 b fffffffa load_back
0c 0 0 00000000 beq_not_taken
0d 0 0 00000000 beq_taken
0f 0 0 00000000 bne_not_taken
10 0 0 00000000 bne_taken
12 1 d 00000013 jal_link
16 1 0 00000077 ldi_r0
17 1 e 0000000c add_r0
18 0 0 00000000 halt

// File: tb.f
logic/cpu_pkg.sv
logic/mem_bus_if.sv
logic/shared_mem.sv
logic/decoder.sv
logic/reg_file.sv
logic/execute_unit.sv
logic/load_store_unit.sv
logic/core_ctrl.sv
logic/cpu_top.sv
testbench/tb_clock.sv
testbench/tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the cpu testbench with verilator and run it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f tb.f -o tb_cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi
echo "simulation exited with status 0"

// File: testbench/tb_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu import cpu_pkg::*;;

    logic      clk;
    logic      rstn;
    logic      run;
    logic      load_en;
    addr_t     load_addr;
    word_t     load_data;
    logic      retire;
    addr_t     retire_pc;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      halted;

    // program image
    addr_t     prog_addr [$];
    word_t     prog_word [$];
    // expected retire trace
    addr_t     exp_pc [$];
    logic      exp_en [$];
    reg_addr_t exp_rd [$];
    word_t     exp_data [$];
    string     exp_name [$];

    int        cycles = 0;
    int        cycle_limit = 0;
    int        rec_idx = 0;

    tb_clock i_clock (.clk(clk), .rstn(rstn));

    cpu_top i_dut (
        .clk(clk), .rstn(rstn), .run(run),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .retire(retire), .retire_pc(retire_pc),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .halted(halted)
    );

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // skips blank lines and lines starting with #
    task automatic next_data_line(input int fd, output string line);
        int    status;
        string raw;
        line = "";
        while (line.len() == 0) begin
            raw = "";
            status = $fgets(raw, fd);
            if (status == 0) begin
                stop_on_error("input file ended before all entries were read");
            end else if (raw.len() > 1 && raw[0] != "#") begin
                line = raw;
            end
        end
    endtask

    task automatic read_input_file();
        int          fd;
        int          count;
        int          n;
        string       line;
        string       name;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        fd = $fopen("testbench/program_input.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open testbench/program_input.txt");
        end
        next_data_line(fd, line);
        n = $sscanf(line, "%d", count);
        if (n != 1) begin
            stop_on_error("program word count missing in input file");
        end
        for (int i = 0; i < count; i++) begin
            next_data_line(fd, line);
            n = $sscanf(line, "%h %h", f0, f1);
            if (n != 2) begin
                stop_on_error({"bad program line in input file: ", line});
            end
            prog_addr.push_back(f0[addr_w-1:0]);
            prog_word.push_back(f1);
        end
        next_data_line(fd, line);
        n = $sscanf(line, "%d", count);
        if (n != 1) begin
            stop_on_error("record count missing in input file");
        end
        for (int i = 0; i < count; i++) begin
            next_data_line(fd, line);
            n = $sscanf(line, "%h %h %h %h %s", f0, f1, f2, f3, name);
            if (n != 5) begin
                stop_on_error({"bad record line in input file: ", line});
            end
            exp_pc.push_back(f0[addr_w-1:0]);
            exp_en.push_back(f1[0]);
            exp_rd.push_back(f2[reg_w-1:0]);
            exp_data.push_back(f3);
            exp_name.push_back(name);
        end
        $fclose(fd);
    endtask

    task automatic wait_for_reset();
        @(posedge clk);
        while (rstn !== 1'b1) begin
            @(posedge clk);
        end
    endtask

    // one word per cycle through the loader port, then start the core
    task automatic load_program();
        for (int i = 0; i < prog_addr.size(); i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= prog_addr[i];
            load_data <= prog_word[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        run     <= 1'b1;
    endtask

    task automatic check_retire(input int idx);
        string name;
        name = exp_name[idx];
        check_addr({name, " retire_pc"}, exp_pc[idx], retire_pc);
        check_bit({name, " wb_en"}, exp_en[idx], wb_en);
        // rd and data carry meaning only with the write port enabled
        if (exp_en[idx]) begin
            check_reg({name, " wb_addr"}, exp_rd[idx], wb_addr);
            check_word({name, " wb_data"}, exp_data[idx], wb_data);
        end
    endtask

    task automatic watch_retires();
        bit finished;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (retire === 1'b1) begin
                if (rec_idx >= exp_pc.size()) begin
                    stop_on_error("a retire arrived after the last expected record");
                end else begin
                    check_retire(rec_idx);
                    rec_idx++;
                end
            end
            if (halted === 1'b1) begin
                if (rec_idx != exp_pc.size()) begin
                    stop_on_error($sformatf("core halted after %0d of %0d expected records",
                                            rec_idx, exp_pc.size()));
                end
                finished = 1'b1;
            end
        end
        // halt holds and nothing retires behind it
        repeat (8) begin
            @(negedge clk);
            if (retire !== 1'b0 || halted !== 1'b1) begin
                stop_on_error("core retired an instruction or left halt after halting");
            end
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            stop_on_error($sformatf("timeout: core did not halt within %0d cycles",
                                    cycle_limit));
        end
    end

    initial begin
        run       <= 1'b0;
        load_en   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        read_input_file();
        // 64 cycles per retire, the load cycles and some room for reset
        cycle_limit = 64 * exp_pc.size() + prog_addr.size() + 16;
        wait_for_reset();
        load_program();
        watch_retires();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

// 8 ns clock, reset held low for the first three rising edges
module tb_clock (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rstn <= 1'b0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

`default_nettype wire

// File: logic/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  wire        clk,
    input  wire        rstn,
    input  wire        run,
    input  wire        load_en,
    input  wire addr_t load_addr,
    input  wire word_t load_data,
    output logic       retire,
    output addr_t      retire_pc,
    output logic       wb_en,
    output reg_addr_t  wb_addr,
    output word_t      wb_data,
    output logic       halted
);

    mem_bus_if fetch_bus ();
    mem_bus_if lsu_bus ();
    decoded_if dec_if ();

    inst_t     inst;
    addr_t     pc;
    word_t     opa;
    word_t     opb;
    word_t     result;
    addr_t     next_pc;
    addr_t     mem_addr;
    logic      lsu_start;
    logic      lsu_store;
    logic      lsu_done;
    word_t     lsu_data;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    shared_mem i_mem (
        .clk(clk), .rstn(rstn),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .fetch_bus(fetch_bus.arbiter), .lsu_bus(lsu_bus.arbiter)
    );

    decoder i_dec (.inst(inst), .dec(dec_if.producer));

    reg_file i_rf (
        .clk(clk), .rstn(rstn),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .raddr_a(dec_if.rs1), .raddr_b(dec_if.rs2),
        .rdata_a(opa), .rdata_b(opb)
    );

    execute_unit i_exe (
        .dec(dec_if.consumer), .pc(pc), .opa(opa), .opb(opb),
        .result(result), .next_pc(next_pc), .mem_addr(mem_addr)
    );

    // store data comes straight from rs2
    load_store_unit i_lsu (
        .clk(clk), .rstn(rstn),
        .start(lsu_start), .is_store(lsu_store),
        .addr(mem_addr), .store_data(opb),
        .done(lsu_done), .load_data(lsu_data),
        .bus(lsu_bus.requester)
    );

    core_ctrl i_ctrl (
        .clk(clk), .rstn(rstn), .run(run),
        .fetch_bus(fetch_bus.requester), .dec(dec_if.consumer),
        .inst(inst), .pc(pc), .result(result), .next_pc(next_pc),
        .lsu_start(lsu_start), .lsu_store(lsu_store),
        .lsu_done(lsu_done), .lsu_data(lsu_data),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .retire(retire), .retire_pc(retire_pc), .halted(halted)
    );

    // write port as seen at the retire pulse
    assign wb_en   = rf_we;
    assign wb_addr = rf_waddr;
    assign wb_data = rf_wdata;

endmodule

`default_nettype wire

// File: logic/core_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module core_ctrl import cpu_pkg::*; (
    input  wire            clk,
    input  wire            rstn,
    input  wire            run,
    mem_bus_if.requester   fetch_bus,
    decoded_if.consumer    dec,
    output inst_t          inst,
    output addr_t          pc,
    input  wire word_t     result,
    input  wire addr_t     next_pc,
    output logic           lsu_start,
    output logic           lsu_store,
    input  wire            lsu_done,
    input  wire word_t     lsu_data,
    output logic           rf_we,
    output reg_addr_t      rf_waddr,
    output word_t          rf_wdata,
    output logic           retire,
    output addr_t          retire_pc,
    output logic           halted
);

    core_state_t state;
    addr_t       pc_next_q;
    logic        wb_en_q;
    logic        halt_q;

    // fetch only reads, at the current pc
    assign fetch_bus.we    = 1'b0;
    assign fetch_bus.wdata = '0;
    assign fetch_bus.addr  = pc;

    assign lsu_start = (state == st_execute) && dec.is_mem;
    assign lsu_store = (dec.op == op_st);

    assign rf_we     = retire && wb_en_q;
    assign retire_pc = pc;
    assign halted    = (state == st_halt);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state         <= st_idle;
            pc            <= '0;
            fetch_bus.req <= 1'b0;
            retire        <= 1'b0;
            wb_en_q       <= 1'b0;
            halt_q        <= 1'b0;
        end else begin
            retire <= 1'b0;
            case (state)
                st_idle: begin
                    if (run) begin
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    fetch_bus.req <= 1'b1;
                    state         <= st_fetch_wait;
                end
                st_fetch_wait: begin
                    if (fetch_bus.ack) begin
                        fetch_bus.req <= 1'b0;
                        state         <= st_decode;
                    end
                end
                // register reads settle on the new instruction
                st_decode: begin
                    state <= st_execute;
                end
                st_execute: begin
                    wb_en_q <= dec.writes_rd;
                    halt_q  <= (dec.op == op_halt);
                    if (dec.is_mem) begin
                        state <= st_mem_wait;
                    end else begin
                        retire <= 1'b1;
                        state  <= st_write;
                    end
                end
                st_mem_wait: begin
                    if (lsu_done) begin
                        retire <= 1'b1;
                        state  <= st_write;
                    end
                end
                st_write: begin
                    pc    <= pc_next_q;
                    state <= halt_q ? st_halt : st_fetch;
                end
                default: begin
                    state <= st_halt;
                end
            endcase
        end
    end

    // instruction and write-back payload
    always_ff @(posedge clk) begin
        if (state == st_fetch_wait && fetch_bus.ack) begin
            inst <= fetch_bus.rdata;
        end
        if (state == st_execute) begin
            rf_waddr  <= dec.rd;
            rf_wdata  <= result;
            pc_next_q <= next_pc;
        end
        if (state == st_mem_wait && lsu_done) begin
            rf_wdata <= lsu_data;
        end
    end

    a_retire_in_write: assert property (@(posedge clk) disable iff (!rstn)
        retire |-> state == st_write);

endmodule

`default_nettype wire

// File: logic/load_store_unit.sv
`timescale 1ns/1ns
`default_nettype none

module load_store_unit import cpu_pkg::*; (
    input  wire          clk,
    input  wire          rstn,
    input  wire          start,
    input  wire          is_store,
    input  wire addr_t   addr,
    input  wire word_t   store_data,
    output logic         done,
    output word_t        load_data,
    mem_bus_if.requester bus
);

    word_t load_q;

    // req stays up until the ack cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            bus.req <= 1'b0;
        end else if (start) begin
            bus.req <= 1'b1;
        end else if (bus.ack) begin
            bus.req <= 1'b0;
        end
    end

    // request fields, held for the whole transaction
    always_ff @(posedge clk) begin
        if (start) begin
            bus.we    <= is_store;
            bus.addr  <= addr;
            bus.wdata <= store_data;
        end
        if (bus.ack) begin
            load_q <= bus.rdata;
        end
    end

    assign done = bus.ack;
    // bypass so data is valid alongside done
    assign load_data = bus.ack ? bus.rdata : load_q;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rstn)
        start |-> !bus.req);

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit import cpu_pkg::*; (
    decoded_if.consumer dec,
    input  wire addr_t  pc,
    input  wire word_t  opa,
    input  wire word_t  opb,
    output word_t       result,
    output addr_t       next_pc,
    output addr_t       mem_addr
);

    word_t sum_imm;
    addr_t pc_inc;
    addr_t pc_rel;
    logic  less;

    assign sum_imm  = opa + dec.imm;
    assign mem_addr = sum_imm[addr_w-1:0];
    // targets wrap with the 8-bit pc
    assign pc_inc   = pc + addr_t'(1);
    assign pc_rel   = pc + dec.imm[addr_w-1:0];
    assign less     = $signed(opa) < $signed(opb);

    always_comb begin
        result  = '0;
        next_pc = pc_inc;
        case (dec.op)
            op_add:  result = opa + opb;
            op_sub:  result = opa - opb;
            op_and:  result = opa & opb;
            op_or:   result = opa | opb;
            op_xor:  result = opa ^ opb;
            op_slt:  result = {{(word_w-1){1'b0}}, less};
            op_addi: result = sum_imm;
            op_ldi:  result = dec.imm;
            op_beq: begin
                if (opa == opb) begin
                    next_pc = pc_rel;
                end
            end
            op_bne: begin
                if (opa != opb) begin
                    next_pc = pc_rel;
                end
            end
            op_jal: begin
                result  = {{(word_w-addr_w){1'b0}}, pc_inc};
                next_pc = pc_rel;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  wire            clk,
    input  wire            rstn,
    input  wire            we,
    input  wire reg_addr_t waddr,
    input  wire word_t     wdata,
    input  wire reg_addr_t raddr_a,
    input  wire reg_addr_t raddr_b,
    output word_t          rdata_a,
    output word_t          rdata_b
);

    word_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

// File: logic/decoder.sv
`timescale 1ns/1ns
`default_nettype none

module decoder import cpu_pkg::*; (
    input  wire inst_t  inst,
    decoded_if.producer dec
);

    // op | rd | rs1 | rs2 | imm16
    assign dec.op  = inst[31:28];
    assign dec.rd  = inst[27:24];
    assign dec.rs1 = inst[23:20];
    assign dec.rs2 = inst[19:16];
    assign dec.imm = {{(word_w-16){inst[15]}}, inst[15:0]};

    always_comb begin
        dec.writes_rd = 1'b0;
        dec.is_mem    = 1'b0;
        case (dec.op)
            op_add,
            op_sub,
            op_and,
            op_or,
            op_xor,
            op_slt,
            op_addi,
            op_ldi: begin
                dec.writes_rd = 1'b1;
            end
            op_ld: begin
                dec.writes_rd = 1'b1;
                dec.is_mem    = 1'b1;
            end
            op_st: begin
                dec.is_mem = 1'b1;
            end
            // link register
            op_jal: begin
                dec.writes_rd = 1'b1;
            end
            // branches, halt and unknown codes write nothing
            default: begin
                dec.writes_rd = 1'b0;
                dec.is_mem    = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/shared_mem.sv
`timescale 1ns/1ns
`default_nettype none

module shared_mem import cpu_pkg::*; (
    input  wire        clk,
    input  wire        rstn,
    input  wire        load_en,
    input  wire addr_t load_addr,
    input  wire word_t load_data,
    mem_bus_if.arbiter fetch_bus,
    mem_bus_if.arbiter lsu_bus
);

    word_t mem [mem_words];

    logic  busy;
    logic  busy_lsu;
    word_t rdata_q;

    logic  grant_lsu;
    logic  grant_fetch;
    logic  gnt_we;
    addr_t gnt_addr;
    word_t gnt_wdata;

    // loader wins outright, then lsu, then fetch
    assign grant_lsu   = !load_en && !busy && lsu_bus.req;
    assign grant_fetch = !load_en && !busy && !lsu_bus.req && fetch_bus.req;

    always_comb begin
        gnt_we    = grant_lsu ? lsu_bus.we    : fetch_bus.we;
        gnt_addr  = grant_lsu ? lsu_bus.addr  : fetch_bus.addr;
        gnt_wdata = grant_lsu ? lsu_bus.wdata : fetch_bus.wdata;
    end

    // busy covers the ack cycle of a granted request
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy     <= 1'b0;
            busy_lsu <= 1'b0;
        end else begin
            busy <= grant_lsu || grant_fetch;
            if (grant_lsu || grant_fetch) begin
                busy_lsu <= grant_lsu;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if ((grant_lsu || grant_fetch) && gnt_we) begin
            mem[gnt_addr] <= gnt_wdata;
        end
        if (grant_lsu || grant_fetch) begin
            rdata_q <= mem[gnt_addr];
        end
    end

    assign fetch_bus.rdata = rdata_q;
    assign lsu_bus.rdata   = rdata_q;
    assign fetch_bus.ack   = busy && !busy_lsu;
    assign lsu_bus.ack     = busy && busy_lsu;

    a_one_ack: assert property (@(posedge clk) disable iff (!rstn)
        !(fetch_bus.ack && lsu_bus.ack));

    a_fetch_ack_req: assert property (@(posedge clk) disable iff (!rstn)
        fetch_bus.ack |-> fetch_bus.req);

    a_lsu_ack_req: assert property (@(posedge clk) disable iff (!rstn)
        lsu_bus.ack |-> lsu_bus.req);

endmodule

`default_nettype wire

// File: logic/mem_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

// one requester to the shared memory
interface mem_bus_if import cpu_pkg::*;;
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    word_t rdata;
    logic  ack;

    modport requester (output req, we, addr, wdata, input rdata, ack);
    modport arbiter (input req, we, addr, wdata, output rdata, ack);
endinterface

// fields of the current instruction, as seen by control and execute
interface decoded_if import cpu_pkg::*;;
    opcode_t   op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;
    logic      writes_rd;
    logic      is_mem;

    modport producer (output op, rd, rs1, rs2, imm, writes_rd, is_mem);
    modport consumer (input op, rd, rs1, rs2, imm, writes_rd, is_mem);
endinterface

`default_nettype wire

// File: logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // datapath widths
    localparam int word_w = 32;
    localparam int addr_w = 8;
    localparam int reg_w  = 4;
    localparam int op_w   = 4;

    localparam int mem_words = 256;
    localparam int num_regs  = 16;

    typedef logic [word_w-1:0] word_t;
    typedef logic [word_w-1:0] inst_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [reg_w-1:0]  reg_addr_t;
    typedef logic [op_w-1:0]   opcode_t;

    // register-register alu group
    localparam opcode_t op_add  = 4'd0;
    localparam opcode_t op_sub  = 4'd1;
    localparam opcode_t op_and  = 4'd2;
    localparam opcode_t op_or   = 4'd3;
    localparam opcode_t op_xor  = 4'd4;
    localparam opcode_t op_slt  = 4'd5;
    // immediate forms
    localparam opcode_t op_addi = 4'd6;
    localparam opcode_t op_ldi  = 4'd7;
    // memory
    localparam opcode_t op_ld   = 4'd8;
    localparam opcode_t op_st   = 4'd9;
    // control flow, targets are pc relative
    localparam opcode_t op_beq  = 4'd10;
    localparam opcode_t op_bne  = 4'd11;
    localparam opcode_t op_jal  = 4'd12;
    localparam opcode_t op_halt = 4'd15;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_execute,
        st_mem_wait,
        st_write,
        st_halt
    } core_state_t;

endpackage

`default_nettype wire
